// ==== rb_pkg.sv ====
/* widths, vector types and the fetch/issue lane group structs
   shared by the instruction queue blocks */

package rb_pkg;

	// sizing
	localparam int DATA_W = 32;	// instruction word
	localparam int DEPTH = 16;	// queue entries
	localparam int LANES = 4;	// write and read lanes
	localparam int IDX_W = 4;	// entry index, DEPTH is a power of two
	localparam int CNT_W = 3;	// lane count 0..LANES

	// vectors with a meaning
	typedef logic [DATA_W-1:0]	inst_t;
	typedef logic [IDX_W-1:0]	idx_t;
	typedef logic [CNT_W-1:0]	cnt_t;
	typedef logic [LANES-1:0]	lane_mask_t;

	// fetch side group, sparse from fetch or packed toward the buffer
	typedef struct packed {
		lane_mask_t			mask;	// slot valid
		inst_t [LANES-1:0]	inst;
	} fetch_group_t;

	// registered group handed to decode
	typedef struct packed {
		lane_mask_t			mask;	// contiguous from lane 0
		inst_t [LANES-1:0]	inst;
	} issue_group_t;

endpackage

// ==== ring_buf.sv ====
/* multi-port circular buffer, head/tail pointers with
   per-entry valid bits, flush and a busy level */

`timescale 1ns/1ns

module ring_buf (
	input logic								clk,
	input logic								reset_,
	input logic								flush,		// clears every entry
	input rb_pkg::lane_mask_t				we,			// write enable per lane
	input rb_pkg::fetch_group_t				wd,			// packed write lanes
	input rb_pkg::lane_mask_t				re,			// read enable per lane
	output rb_pkg::inst_t [rb_pkg::LANES-1:0]	rd,		// oldest LANES entries
	output rb_pkg::lane_mask_t				rv,			// read lane holds an entry
	output logic							busy		// no room for a full group
);

	import rb_pkg::*;

	// storage
	inst_t				mem [DEPTH];
	logic [DEPTH-1:0]	valid;
	idx_t				head;		// next free slot
	idx_t				tail;		// oldest entry

	// lane addressing
	idx_t [LANES-1:0]	wr_addr;
	idx_t [LANES-1:0]	rd_addr;
	idx_t				chk_ptr;

	// qualified enables and their counts
	lane_mask_t			wr_en;
	lane_mask_t			rd_en;
	cnt_t				wnum;
	cnt_t				rnum;

	// lane i sits at pointer plus i, wrap comes from the index width
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			wr_addr[i] = head + idx_t'(i);
			rd_addr[i] = tail + idx_t'(i);
		end
	end

	// read lanes straight from tail
	always_comb begin
		for (int j = 0; j < LANES; j++) begin
			rd[j] = mem[rd_addr[j]];
			rv[j] = valid[rd_addr[j]];
		end
	end

	// a lane writes only if packed valid and enabled
	assign wr_en = we & wd.mask;
	assign rd_en = re & rv;		// never pop an empty slot

	assign wnum = cnt_t'($countones(wr_en));
	assign rnum = cnt_t'($countones(rd_en));

	/* entries run contiguously from tail up to head, so if the last slot
	   of a full group is taken then fewer than LANES slots are free */
	assign chk_ptr = head + idx_t'(LANES - 1);
	assign busy = valid[chk_ptr];

	// pointers and valid bits
	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			head <= '0;
			tail <= '0;
			valid <= '0;
		end else if (flush) begin
			head <= '0;		// flush wins over this cycle's traffic
			tail <= '0;
			valid <= '0;
		end else begin
			head <= head + idx_t'(wnum);
			tail <= tail + idx_t'(rnum);
			for (int i = 0; i < LANES; i++) begin
				if (wr_en[i]) begin
					valid[wr_addr[i]] <= 1'b1;
				end
			end
			// reads hit occupied slots, writes hit free ones
			for (int j = 0; j < LANES; j++) begin
				if (rd_en[j]) begin
					valid[rd_addr[j]] <= 1'b0;
				end
			end
		end
	end

	// instruction storage
	always_ff @(posedge clk) begin
		for (int i = 0; i < LANES; i++) begin
			if (wr_en[i] && !flush) begin
				mem[wr_addr[i]] <= wd.inst[i];
			end
		end
	end

endmodule

// ==== fetch_pack.sv ====
/* fetch group compaction into contiguous low write lanes,
   write enables and the fetch accept level */

`timescale 1ns/1ns

module fetch_pack (
	input rb_pkg::fetch_group_t		fetch,			// sparse group from fetch
	input logic						busy,			// buffer has no room for a group
	output rb_pkg::lane_mask_t		we,				// write enables, low lanes only
	output rb_pkg::fetch_group_t	wd,				// packed group
	output logic					fetch_accept	// group taken at this edge
);

	import rb_pkg::*;

	fetch_group_t	packed_grp;
	cnt_t			nvalid;		// valid slots seen so far

	/* walk the fetch slots in order and drop each valid one into the
	   next free low lane, so relative order is kept */
	always_comb begin
		packed_grp = '0;
		nvalid = '0;
		for (int i = 0; i < LANES; i++) begin
			if (fetch.mask[i]) begin
				for (int k = 0; k < LANES; k++) begin
					if (cnt_t'(k) == nvalid) begin
						packed_grp.inst[k] = fetch.inst[i];
						packed_grp.mask[k] = 1'b1;
					end
				end
				nvalid = nvalid + 1'b1;
			end
		end
	end

	assign wd = packed_grp;

	// all or nothing, the group waits at fetch while busy
	assign we = busy ? '0 : packed_grp.mask;
	assign fetch_accept = !busy;

endmodule

// ==== issue_select.sv ====
/* read enables from the decode take count, registered
   issue group toward decode */

`timescale 1ns/1ns

module issue_select (
	input logic								clk,
	input logic								reset_,
	input logic								flush,
	input rb_pkg::cnt_t						take,	// decode capacity this cycle
	input rb_pkg::inst_t [rb_pkg::LANES-1:0]	rd,		// oldest entries
	input rb_pkg::lane_mask_t				rv,
	output rb_pkg::lane_mask_t				re,		// entries popped at this edge
	output rb_pkg::issue_group_t			issue
);

	import rb_pkg::*;

	lane_mask_t			issue_mask;
	inst_t [LANES-1:0]	issue_inst;

	// lane j leaves the queue if decode wants it and it is there
	always_comb begin
		for (int j = 0; j < LANES; j++) begin
			re[j] = (cnt_t'(j) < take) && rv[j];
		end
	end

	// rv is contiguous, so re stays contiguous as well
	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			issue_mask <= '0;
		end else if (flush) begin
			issue_mask <= '0;
		end else begin
			issue_mask <= re;
		end
	end

	// only popped lanes load
	always_ff @(posedge clk) begin
		for (int j = 0; j < LANES; j++) begin
			if (re[j]) begin
				issue_inst[j] <= rd[j];
			end
		end
	end

	always_comb begin
		issue.mask = issue_mask;
		issue.inst = issue_inst;
	end

endmodule

// ==== inst_queue.sv ====
/* instruction queue top, packer into ring buffer into issue stage */

`timescale 1ns/1ns

module inst_queue (
	input logic						clk,
	input logic						reset_,
	input logic						flush,			// empties the queue
	input rb_pkg::fetch_group_t		fetch,			// held by fetch until accepted
	output logic					fetch_accept,
	input rb_pkg::cnt_t				take,			// instructions decode can take
	output rb_pkg::issue_group_t	issue			// one cycle after the read
);

	import rb_pkg::*;

	// write side
	lane_mask_t			we;
	fetch_group_t		wd;
	logic				busy;

	// read side
	lane_mask_t			re;
	inst_t [LANES-1:0]	rd;
	lane_mask_t			rv;

	fetch_pack fetch_pack0 (
		.fetch			(fetch),
		.busy			(busy),
		.we				(we),
		.wd				(wd),
		.fetch_accept	(fetch_accept)
	);

	ring_buf ring_buf0 (
		.clk		(clk),
		.reset_		(reset_),
		.flush		(flush),
		.we			(we),
		.wd			(wd),
		.re			(re),
		.rd			(rd),
		.rv			(rv),
		.busy		(busy)
	);

	issue_select issue_select0 (
		.clk		(clk),
		.reset_		(reset_),
		.flush		(flush),
		.take		(take),
		.rd			(rd),
		.rv			(rv),
		.re			(re),
		.issue		(issue)
	);

endmodule

// ==== inst_queue_checker.sv ====
/* concurrent checks on the queue top, issue mask shape and flush recovery */

`timescale 1ns/1ns

module inst_queue_checker (
	input logic						clk,
	input logic						reset_,
	input logic						flush,
	input logic						fetch_accept,
	input rb_pkg::issue_group_t		issue
);

	import rb_pkg::*;

	lane_mask_t mask_inc;

	assign mask_inc = issue.mask + lane_mask_t'(1);	// 0..01..1 plus one clears all ones

	issue_contiguous: assert property (@(posedge clk) disable iff (!reset_)
		(issue.mask & mask_inc) == '0)
		else $error("issue mask %b is not contiguous from lane 0", issue.mask);

	flush_clears_issue: assert property (@(posedge clk) disable iff (!reset_)
		flush |=> issue.mask == '0)
		else $error("issue mask %b not cleared after flush", issue.mask);

	// queue is empty after a flush, so room for a group
	flush_frees_fetch: assert property (@(posedge clk) disable iff (!reset_)
		flush |=> fetch_accept)
		else $error("fetch_accept low in the cycle after flush");

endmodule

bind inst_queue inst_queue_checker checker0 (
	.clk			(clk),
	.reset_			(reset_),
	.flush			(flush),
	.fetch_accept	(fetch_accept),
	.issue			(issue)
);

// ==== tb_inst_queue.sv ====
/* testbench for the instruction queue, random fetch and take stimulus,
   queue reference model, per-cycle comparison and reporting */

`timescale 1ns/1ns

module tb_inst_queue;

	import rb_pkg::*;

	localparam int TIMEOUT_CYC = 2000;	// about 700 cycles of tests plus margin

	logic			clk;
	logic			reset_;
	logic			flush;
	fetch_group_t	fetch;
	logic			fetch_accept;
	cnt_t			take;
	issue_group_t	issue;

	integer			seed;
	logic [15:0]	next_id;		// unique tag in the low half of each instruction
	inst_t			model_q[$];		// queue contents in age order
	issue_group_t	exp_issue;		// predicted issue after the coming edge
	logic			checking;
	logic			group_done;		// offered group consumed at the last edge
	logic			seen_busy;
	string			cur_test;
	int				errors;
	int				checks;
	int				test_errs0;
	int				tests_run;
	int				tests_failed;
	int				cycles;

	inst_queue dut0 (
		.clk			(clk),
		.reset_			(reset_),
		.flush			(flush),
		.fetch			(fetch),
		.fetch_accept	(fetch_accept),
		.take			(take),
		.issue			(issue)
	);

	always #20 clk = ~clk;

	// oldest min(take, visible) entries land in the low issue lanes
	function automatic issue_group_t expect_issue(input inst_t q[$], input cnt_t take_n,
			input int visible);
		issue_group_t g;
		int n;
		g = '0;
		n = int'(take_n);
		if (n > visible) n = visible;
		if (n > LANES) n = LANES;
		for (int j = 0; j < n; j++) begin
			g.mask[j] = 1'b1;
			g.inst[j] = q[j];
		end
		return g;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = $random(seed);
		return lo + int'(r % 32'(hi - lo + 1));
	endfunction

	// kind 0 empty, 1 sparse, 2 full
	task automatic new_group(input int kind);
		fetch_group_t g;
		logic [31:0] r;
		g = '0;
		for (int i = 0; i < LANES; i++) begin
			r = $random(seed);
			case (kind)
				0: g.mask[i] = 1'b0;
				1: g.mask[i] = r[31];
				default: g.mask[i] = 1'b1;
			endcase
			if (g.mask[i]) begin
				g.inst[i] = {r[15:0], next_id};
				next_id = next_id + 16'd1;
			end else begin
				g.inst[i] = r;	// junk in dead slots
			end
		end
		fetch = g;
	endtask

	// one cycle of stimulus, driven just after the edge
	task automatic step(input int kind, input int take_lo, input int take_hi,
			input logic do_flush);
		@(posedge clk);
		#2;
		if (group_done) new_group(kind);	// otherwise fetch holds the group
		take = cnt_t'(rand_range(take_lo, take_hi));
		flush = do_flush;
		if (!fetch_accept) seen_busy = 1'b1;
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errs0 = errors;
	endtask

	task automatic end_test();
		@(negedge clk);	// last prediction of the test is compared here
		#1;
		tests_run++;
		if (errors == test_errs0) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, errors - test_errs0);
		end
	endtask

	// compare last prediction, then predict the next edge from stable inputs
	always @(negedge clk) begin : compare_model
		logic acc;
		if (checking) begin
			checks++;
			if (issue.mask !== exp_issue.mask) begin
				$display("FAILED %s issue mask: expected %b actual %b",
					cur_test, exp_issue.mask, issue.mask);
				errors++;
			end
			for (int j = 0; j < LANES; j++) begin
				if (exp_issue.mask[j] && issue.inst[j] !== exp_issue.inst[j]) begin
					$display("FAILED %s issue lane %0d: expected %h actual %h",
						cur_test, j, exp_issue.inst[j], issue.inst[j]);
					errors++;
				end
			end
			acc = (DEPTH - model_q.size()) >= LANES;
			if (fetch_accept !== acc) begin
				$display("FAILED %s fetch_accept: expected %b actual %b",
					cur_test, acc, fetch_accept);
				errors++;
			end
			if (flush) begin
				exp_issue = '0;
				model_q.delete();
			end else begin
				exp_issue = expect_issue(model_q, take, model_q.size());
				for (int j = 0; j < LANES; j++) begin
					if (exp_issue.mask[j]) void'(model_q.pop_front());
				end
				// pushed after the pops, not visible until next cycle
				if (acc) begin
					for (int i = 0; i < LANES; i++) begin
						if (fetch.mask[i]) model_q.push_back(fetch.inst[i]);
					end
				end
			end
			group_done = flush || acc;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYC) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		seed = 32'h455b8fa3;
		clk = 1'b0;
		reset_ = 1'b0;
		flush = 1'b0;
		take = '0;
		fetch = '0;
		next_id = '0;
		exp_issue = '0;
		checking = 1'b0;
		group_done = 1'b1;
		seen_busy = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;
		repeat (8) @(posedge clk);
		#2;
		reset_ = 1'b1;
		checking = 1'b1;

		begin_test("reset_state");
		@(negedge clk);
		if (issue.mask !== '0) begin
			$display("FAILED %s issue mask: expected %b actual %b", cur_test, 4'b0, issue.mask);
			errors++;
		end
		if (fetch_accept !== 1'b1) begin
			$display("FAILED %s fetch_accept: expected 1 actual %b", cur_test, fetch_accept);
			errors++;
		end
		end_test();

		begin_test("sparse_pack");
		repeat (200) step(1, LANES, LANES, 1'b0);
		end_test();

		begin_test("fill_backpressure");
		seen_busy = 1'b0;
		repeat (40) step(2, 0, 0, 1'b0);
		if (!seen_busy) begin
			$display("%s: fetch_accept never fell while the queue filled", cur_test);
			errors++;
		end
		repeat (20) step(0, LANES, LANES, 1'b0);	// drain everything held
		if (fetch_accept !== 1'b1) begin
			$display("%s: fetch_accept still low after draining", cur_test);
			errors++;
		end
		end_test();

		begin_test("partial_take");
		repeat (300) step(1, 0, LANES, 1'b0);
		end_test();

		begin_test("flush");
		repeat (3) begin
			repeat (12) step(2, 0, 1, 1'b0);
			step(1, 0, LANES, 1'b1);
			step(1, 0, LANES, 1'b0);
			@(negedge clk);
			if (issue.mask !== '0) begin
				$display("FAILED %s issue mask after flush: expected %b actual %b",
					cur_test, 4'b0, issue.mask);
				errors++;
			end
			repeat (25) step(1, 1, LANES, 1'b0);
		end
		end_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
rb_pkg.sv
ring_buf.sv
fetch_pack.sv
issue_select.sv
inst_queue.sv
inst_queue_checker.sv
tb_inst_queue.sv

// ==== run.sh ====
#!/bin/bash
# build and run the instruction queue testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_inst_queue \
	-f sim.f -o sim_inst_queue
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_inst_queue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
	exit 0
fi
exit 1
